//--- project.f
+incdir+hw
+incdir+test
hw/riscv_pkg.sv
hw/riscv_fetch.sv
hw/riscv_decode.sv
hw/riscv_execute.sv
hw/riscv_writeback.sv
hw/riscv_datapath.sv
test/riscv_datapath_tb.sv

//--- test/riscv_datapath_table.svh
// one row per fetched instruction
// columns: instruction word, random-immediate flag, decode controls, stall and flush levels
// consumers stay at least two rows behind their producers

localparam int NROWS = 25;

row_t tab [NROWS] = '{
  addi(1, 0, -5, 1'b0),             // negative immediate
  addi(2, 0, 100, 1'b0),
  lui(3, 20'h80000),                // upper bit set, sign extends
  alu_r(alu_add, 4, 1, 2),          // x2 arrives by write-through
  alu_r(alu_sub, 5, 1, 2),
  alu_r(alu_sll, 6, 2, 1),          // shamt from low six bits of -5
  alu_r(alu_slt, 7, 1, 2),
  alu_r(alu_sltu, 8, 1, 2),
  alu_r(alu_xor, 9, 3, 1),
  alu_r(alu_srl, 10, 3, 2),
  alu_r(alu_sra, 11, 3, 2),         // negative operand
  alu_r(alu_or, 12, 1, 3),
  alu_r(alu_and, 13, 3, 1),
  addi(0, 2, 7, 1'b0),              // rd x0, no write
  alu_r(alu_add, 14, 0, 2),         // x0 reads zero
  auipc(15, 20'h12345),
  addi(16, 2, 0, 1'b1),
  stall_row(),                      // row 16 held in decode
  addi(17, 16, 0, 1'b1),
  de_flush(addi(18, 0, 55, 1'b0)),  // cancelled in decode/execute
  fd_flush(addi(19, 0, 66, 1'b0)),  // cancelled in fetch/decode
  alu_r(alu_add, 20, 17, 16),
  auipc(21, 20'h00001),
  alu_r(alu_xor, 22, 15, 12),
  addi(23, 4, -2048, 1'b0)
};

//--- test/riscv_datapath_tb.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_datapath_tb;

  import riscv_pkg::*;

  localparam int PERIOD = 4;

  typedef struct packed {
    logic [31:0] inst;
    logic        rnd;      // imm12 replaced by a random value
    imm_sel_e    immsrc;
    logic        asel;
    logic        bsel;
    alu_op_e     aluctrl;
    res_sel_e    resultsrc;
    logic        regw;
    logic        stall;
    logic        flush_fd;
    logic        flush_de;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  stallpc;
  logic                  stall_fd;
  logic                  flush_fd;
  logic                  flush_de;
  logic [`RV_INST_W-1:0] inst;
  imm_sel_e              immsrc;
  logic                  asel;
  logic                  bsel;
  alu_op_e               aluctrl;
  res_sel_e              resultsrc;
  logic                  regw;
  logic [`RV_XLEN-1:0]   pc;
  logic [6:0]            opcode;
  logic [2:0]            func3;
  logic                  func7_5;
  logic                  regw_wb;
  logic [`RV_REG_AW-1:0] rdaddr_wb;
  logic [`RV_XLEN-1:0]   rddata_wb;

  function automatic row_t alu_r(alu_op_e op, int rd, int rs1, int rs2);
    row_t r;
    logic [2:0] f3;
    logic [6:0] f7;
    case (op)
      alu_sll:  f3 = 3'd1;
      alu_slt:  f3 = 3'd2;
      alu_sltu: f3 = 3'd3;
      alu_xor:  f3 = 3'd4;
      alu_srl, alu_sra: f3 = 3'd5;
      alu_or:   f3 = 3'd6;
      alu_and:  f3 = 3'd7;
      default:  f3 = 3'd0;
    endcase
    f7 = (op == alu_sub || op == alu_sra) ? 7'h20 : 7'h00;
    r = '0;
    r.inst = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    r.aluctrl = op;
    r.regw = 1'b1;
    return r;
  endfunction

  function automatic row_t addi(int rd, int rs1, int imm, logic rnd);
    row_t r;
    r = '0;
    r.inst = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    r.rnd = rnd;
    r.immsrc = imm_i;
    r.bsel = 1'b1;
    r.aluctrl = alu_add;
    r.regw = 1'b1;
    return r;
  endfunction

  function automatic row_t lui(int rd, logic [19:0] imm);
    row_t r;
    r = '0;
    r.inst = {imm, rd[4:0], 7'h37};
    r.immsrc = imm_u;
    r.resultsrc = res_imm;
    r.regw = 1'b1;
    return r;
  endfunction

  function automatic row_t auipc(int rd, logic [19:0] imm);
    row_t r;
    r = '0;
    r.inst = {imm, rd[4:0], 7'h17};
    r.immsrc = imm_u;
    r.asel = 1'b1;
    r.bsel = 1'b1;
    r.regw = 1'b1;
    return r;
  endfunction

  // controls of a stall row apply to the repeated instruction
  function automatic row_t stall_row();
    row_t r;
    r = '0;
    r.stall = 1'b1;
    r.flush_de = 1'b1;
    return r;
  endfunction

  function automatic row_t fd_flush(row_t r);
    r.flush_fd = 1'b1;
    r.regw = 1'b0;  // control sees the zero word
    return r;
  endfunction

  function automatic row_t de_flush(row_t r);
    r.flush_de = 1'b1;
    return r;
  endfunction

  `include "riscv_datapath_table.svh"

  logic [`RV_XLEN-1:0] model_regs [32];
  logic [`RV_XLEN-1:0] pc_exp [NROWS];
  logic [`RV_REG_AW-1:0] q_rd [$];
  logic [`RV_XLEN-1:0] q_data [$];
  logic [`RV_INST_W-1:0] dec_exp;  // word expected in fetch/decode
  integer seed = 93465;
  int value_errs = 0;
  int flow_errs = 0;
  logic running = 1'b0;

  function automatic logic [`RV_XLEN-1:0] alu_model(alu_op_e op,
                                                    logic [`RV_XLEN-1:0] a,
                                                    logic [`RV_XLEN-1:0] b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[5:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_sltu: return (a < b) ? 64'd1 : 64'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[5:0];
      alu_sra:  return $signed(a) >>> b[5:0];
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  // sequential reference that builds expected pc and write queue
  task automatic build_model();
    logic [`RV_XLEN-1:0] mpc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] res;
    row_t r;
    mpc = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int k = 0; k < NROWS; k++) begin
      pc_exp[k] = mpc;
      r = tab[k];
      if (!r.stall) mpc = mpc + 64'd4;
      if (r.stall || r.flush_fd || r.flush_de || !r.regw) continue;
      if (r.immsrc == imm_u) imm = {{32{r.inst[31]}}, r.inst[31:12], 12'b0};
      else imm = {{52{r.inst[31]}}, r.inst[31:20]};
      a = r.asel ? pc_exp[k] : model_regs[r.inst[19:15]];
      b = r.bsel ? imm : model_regs[r.inst[24:20]];
      res = (r.resultsrc == res_imm) ? imm : alu_model(r.aluctrl, a, b);
      if (r.inst[11:7] != 5'd0) begin
        model_regs[r.inst[11:7]] = res;
        q_rd.push_back(r.inst[11:7]);
        q_data.push_back(res);
      end
    end
  endtask

  // fetch side of row c with decode controls of row c-1
  task automatic drive_cycle(input int c);
    row_t f;
    row_t d;
    f = '0;
    d = '0;
    if (c < NROWS) f = tab[c];
    if (c >= 1 && c <= NROWS) d = tab[c-1];
    inst      <= f.inst;
    stallpc   <= f.stall;
    stall_fd  <= f.stall;
    flush_fd  <= f.flush_fd;
    immsrc    <= d.immsrc;
    asel      <= d.asel;
    bsel      <= d.bsel;
    aluctrl   <= d.aluctrl;
    resultsrc <= d.resultsrc;
    regw      <= d.regw;
    flush_de  <= d.flush_de;
  endtask

  riscv_datapath uut (
    .i_riscv_datapath_clk       (clk),
    .i_rst_n                    (rst_n),
    .i_riscv_datapath_stallpc   (stallpc),
    .i_riscv_datapath_stall_fd  (stall_fd),
    .i_riscv_datapath_flush_fd  (flush_fd),
    .i_riscv_datapath_flush_de  (flush_de),
    .o_riscv_datapath_pc        (pc),
    .i_riscv_datapath_inst      (inst),
    .o_riscv_datapath_opcode    (opcode),
    .o_riscv_datapath_func3     (func3),
    .o_riscv_datapath_func7_5   (func7_5),
    .i_riscv_datapath_immsrc    (immsrc),
    .i_riscv_datapath_asel      (asel),
    .i_riscv_datapath_bsel      (bsel),
    .i_riscv_datapath_aluctrl   (aluctrl),
    .i_riscv_datapath_resultsrc (resultsrc),
    .i_riscv_datapath_regw      (regw),
    .o_riscv_datapath_regw_wb   (regw_wb),
    .o_riscv_datapath_rdaddr_wb (rdaddr_wb),
    .o_riscv_datapath_rddata_wb (rddata_wb)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // writeback port against the model queue
  always @(negedge clk) begin
    if (running && regw_wb) begin
      if (q_rd.size() == 0) begin
        $display("unexpected register write to x%0d at %0t", rdaddr_wb, $time);
        flow_errs++;
      end else begin
        if (rdaddr_wb !== q_rd[0] || rddata_wb !== q_data[0]) begin
          $display("Error at %0t: write x%0d = %h, expected x%0d = %h", $time,
                   rdaddr_wb, rddata_wb, q_rd[0], q_data[0]);
          value_errs++;
        end
        void'(q_rd.pop_front());
        void'(q_data.pop_front());
      end
    end
  end

  initial begin
    #((NROWS + 20) * PERIOD);
    $display("timeout, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    stallpc = 1'b0;
    stall_fd = 1'b0;
    flush_fd = 1'b0;
    flush_de = 1'b0;
    inst = '0;
    immsrc = imm_i;
    asel = 1'b0;
    bsel = 1'b0;
    aluctrl = alu_add;
    resultsrc = res_alu;
    regw = 1'b0;
    dec_exp = '0;
    for (int k = 0; k < NROWS; k++) begin
      if (tab[k].rnd) tab[k].inst[31:20] = $random(seed);
    end
    build_model();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;  // released together with the first row
    running = 1'b1;
    for (int c = 0; c < NROWS + 4; c++) begin
      drive_cycle(c);
      @(negedge clk);
      if (c == 0 && regw_wb !== 1'b0) begin
        $display("Error at %0t: write enable high after reset", $time);
        value_errs++;
      end
      if (c < NROWS && pc !== pc_exp[c]) begin
        $display("Error at %0t: pc %h, expected %h", $time, pc, pc_exp[c]);
        value_errs++;
      end
      // fields sent to the control unit come from the word in decode
      if (opcode !== dec_exp[6:0] || func3 !== dec_exp[14:12] ||
          func7_5 !== dec_exp[30]) begin
        $display("Error at %0t: decode fields %h/%h/%b, expected %h/%h/%b", $time,
                 opcode, func3, func7_5, dec_exp[6:0], dec_exp[14:12], dec_exp[30]);
        value_errs++;
      end
      if (c < NROWS) begin
        if (tab[c].flush_fd) begin
          dec_exp = '0;
        end else if (!tab[c].stall) begin
          dec_exp = tab[c].inst;
        end
      end else begin
        dec_exp = '0;
      end
      @(posedge clk);
    end
    if (q_rd.size() != 0) begin
      $display("%0d expected register writes never came", q_rd.size());
      flow_errs += q_rd.size();
    end
    $display("errors: %0d value, %0d missing or unexpected writes", value_errs, flow_errs);
    if (value_errs == 0 && flow_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- hw/riscv_datapath.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_datapath (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  logic                  i_riscv_datapath_stallpc,
  input  logic                  i_riscv_datapath_stall_fd,
  input  logic                  i_riscv_datapath_flush_fd,
  input  logic                  i_riscv_datapath_flush_de,
  output logic [`RV_XLEN-1:0]   o_riscv_datapath_pc,        // to instruction memory
  input  logic [`RV_INST_W-1:0] i_riscv_datapath_inst,      // from instruction memory
  output logic [6:0]            o_riscv_datapath_opcode,    // to control unit
  output logic [2:0]            o_riscv_datapath_func3,     // to control unit
  output logic                  o_riscv_datapath_func7_5,   // to control unit
  input  riscv_pkg::imm_sel_e   i_riscv_datapath_immsrc,    // controls for decode instr
  input  logic                  i_riscv_datapath_asel,
  input  logic                  i_riscv_datapath_bsel,
  input  riscv_pkg::alu_op_e    i_riscv_datapath_aluctrl,
  input  riscv_pkg::res_sel_e   i_riscv_datapath_resultsrc,
  input  logic                  i_riscv_datapath_regw,
  output logic                  o_riscv_datapath_regw_wb,
  output logic [`RV_REG_AW-1:0] o_riscv_datapath_rdaddr_wb,
  output logic [`RV_XLEN-1:0]   o_riscv_datapath_rddata_wb
);

  import riscv_pkg::*;

  logic [`RV_XLEN-1:0]   pc_d;
  inst_u                 inst_d;
  logic [`RV_REG_AW-1:0] rdaddr_d;
  logic [`RV_XLEN-1:0]   rs1data_d;
  logic [`RV_XLEN-1:0]   rs2data_d;
  logic [`RV_XLEN-1:0]   imm_d;

  logic [`RV_XLEN-1:0]   result_e;
  logic [`RV_XLEN-1:0]   imm_e;
  logic [`RV_REG_AW-1:0] rdaddr_e;
  res_sel_e              resultsrc_e;
  logic                  regw_e;

  riscv_fetch u_riscv_fetch (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_stallpc            (i_riscv_datapath_stallpc),
    .i_stall_fd           (i_riscv_datapath_stall_fd),
    .i_flush_fd           (i_riscv_datapath_flush_fd),
    .i_inst               (i_riscv_datapath_inst),
    .o_pc                 (o_riscv_datapath_pc),
    .o_pc_d               (pc_d),
    .o_inst_d             (inst_d)
  );

  // rs addresses stay inside, no hazard unit in this core
  riscv_decode u_riscv_decode (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_inst               (inst_d),
    .i_immsrc             (i_riscv_datapath_immsrc),
    .i_wb_regw            (o_riscv_datapath_regw_wb),
    .i_wb_rdaddr          (o_riscv_datapath_rdaddr_wb),
    .i_wb_rddata          (o_riscv_datapath_rddata_wb),
    .o_opcode             (o_riscv_datapath_opcode),
    .o_func3              (o_riscv_datapath_func3),
    .o_func7_5            (o_riscv_datapath_func7_5),
    .o_rs1addr            (),
    .o_rs2addr            (),
    .o_rdaddr             (rdaddr_d),
    .o_rs1data            (rs1data_d),
    .o_rs2data            (rs2data_d),
    .o_imm                (imm_d)
  );

  riscv_execute u_riscv_execute (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_flush_de           (i_riscv_datapath_flush_de),
    .i_pc                 (pc_d),
    .i_rs1data            (rs1data_d),
    .i_rs2data            (rs2data_d),
    .i_imm                (imm_d),
    .i_rdaddr             (rdaddr_d),
    .i_asel               (i_riscv_datapath_asel),
    .i_bsel               (i_riscv_datapath_bsel),
    .i_aluctrl            (i_riscv_datapath_aluctrl),
    .i_resultsrc          (i_riscv_datapath_resultsrc),
    .i_regw               (i_riscv_datapath_regw),
    .o_result             (result_e),
    .o_imm_e              (imm_e),
    .o_rdaddr_e           (rdaddr_e),
    .o_resultsrc_e        (resultsrc_e),
    .o_regw_e             (regw_e)
  );

  riscv_writeback u_riscv_writeback (
    .i_riscv_datapath_clk (i_riscv_datapath_clk),
    .i_rst_n              (i_rst_n),
    .i_result             (result_e),
    .i_imm                (imm_e),
    .i_rdaddr             (rdaddr_e),
    .i_resultsrc          (resultsrc_e),
    .i_regw               (regw_e),
    .o_regw_wb            (o_riscv_datapath_regw_wb),
    .o_rdaddr_wb          (o_riscv_datapath_rdaddr_wb),
    .o_rddata_wb          (o_riscv_datapath_rddata_wb)
  );

endmodule

//--- hw/riscv_writeback.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_writeback (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  logic [`RV_XLEN-1:0]   i_result,
  input  logic [`RV_XLEN-1:0]   i_imm,
  input  logic [`RV_REG_AW-1:0] i_rdaddr,
  input  riscv_pkg::res_sel_e   i_resultsrc,
  input  logic                  i_regw,
  output logic                  o_regw_wb,    // also the register file write enable
  output logic [`RV_REG_AW-1:0] o_rdaddr_wb,
  output logic [`RV_XLEN-1:0]   o_rddata_wb
);

  import riscv_pkg::*;

  logic [`RV_XLEN-1:0] result_w;
  logic [`RV_XLEN-1:0] imm_w;
  res_sel_e            resultsrc_w;

  // x0 writes die here, the register file relies on it
  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_regw_wb   <= 1'b0;
      resultsrc_w <= res_alu;
    end else begin
      o_regw_wb   <= i_regw && (i_rdaddr != '0);
      resultsrc_w <= i_resultsrc;
    end
  end

  always_ff @(posedge i_riscv_datapath_clk) begin
    result_w    <= i_result;
    imm_w       <= i_imm;
    o_rdaddr_wb <= i_rdaddr;
  end

  always_comb begin
    case (resultsrc_w)
      res_alu: o_rddata_wb = result_w;
      res_imm: o_rddata_wb = imm_w;     // lui
      default: o_rddata_wb = result_w;
    endcase
  end

endmodule

//--- hw/riscv_execute.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_execute (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  logic                  i_flush_de,
  input  logic [`RV_XLEN-1:0]   i_pc,
  input  logic [`RV_XLEN-1:0]   i_rs1data,
  input  logic [`RV_XLEN-1:0]   i_rs2data,
  input  logic [`RV_XLEN-1:0]   i_imm,
  input  logic [`RV_REG_AW-1:0] i_rdaddr,
  input  logic                  i_asel,       // 1 selects pc
  input  logic                  i_bsel,       // 1 selects immediate
  input  riscv_pkg::alu_op_e    i_aluctrl,
  input  riscv_pkg::res_sel_e   i_resultsrc,
  input  logic                  i_regw,
  output logic [`RV_XLEN-1:0]   o_result,
  output logic [`RV_XLEN-1:0]   o_imm_e,
  output logic [`RV_REG_AW-1:0] o_rdaddr_e,
  output riscv_pkg::res_sel_e   o_resultsrc_e,
  output logic                  o_regw_e
);

  import riscv_pkg::*;

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] pc_e;
  logic [`RV_XLEN-1:0] rs1_e;
  logic [`RV_XLEN-1:0] rs2_e;
  logic                asel_e;
  logic                bsel_e;
  alu_op_e             aluctrl_e;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]  shamt;

  // decode/execute control, a flush leaves a no-write bubble
  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_regw_e      <= 1'b0;
      o_resultsrc_e <= res_alu;
      asel_e        <= 1'b0;
      bsel_e        <= 1'b0;
      aluctrl_e     <= alu_add;
    end else if (i_flush_de) begin
      o_regw_e      <= 1'b0;
      o_resultsrc_e <= res_alu;
      asel_e        <= 1'b0;
      bsel_e        <= 1'b0;
      aluctrl_e     <= alu_add;
    end else begin
      o_regw_e      <= i_regw;
      o_resultsrc_e <= i_resultsrc;
      asel_e        <= i_asel;
      bsel_e        <= i_bsel;
      aluctrl_e     <= i_aluctrl;
    end
  end

  // decode/execute payload
  always_ff @(posedge i_riscv_datapath_clk) begin
    pc_e       <= i_pc;
    rs1_e      <= i_rs1data;
    rs2_e      <= i_rs2data;
    o_imm_e    <= i_imm;
    o_rdaddr_e <= i_rdaddr;
  end

  assign op_a  = asel_e ? pc_e : rs1_e;   // pc for auipc
  assign op_b  = bsel_e ? o_imm_e : rs2_e;
  assign shamt = op_b[SHAMT_W-1:0];       // rv64 uses six bits

  always_comb begin
    case (aluctrl_e)
      alu_add:  o_result = op_a + op_b;
      alu_sub:  o_result = op_a - op_b;
      alu_sll:  o_result = op_a << shamt;
      alu_slt:  o_result = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      alu_sltu: o_result = {{(`RV_XLEN-1){1'b0}}, (op_a < op_b)};
      alu_xor:  o_result = op_a ^ op_b;
      alu_srl:  o_result = op_a >> shamt;
      alu_sra:  o_result = $signed(op_a) >>> shamt;  // keeps the sign bit
      alu_or:   o_result = op_a | op_b;
      alu_and:  o_result = op_a & op_b;
      default:  o_result = '0;
    endcase
  end

endmodule

//--- hw/riscv_decode.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_decode (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  riscv_pkg::inst_u      i_inst,
  input  riscv_pkg::imm_sel_e   i_immsrc,     // from control unit
  input  logic                  i_wb_regw,    // already cleared for x0
  input  logic [`RV_REG_AW-1:0] i_wb_rdaddr,
  input  logic [`RV_XLEN-1:0]   i_wb_rddata,
  output logic [6:0]            o_opcode,     // to control unit
  output logic [2:0]            o_func3,      // to control unit
  output logic                  o_func7_5,    // to control unit
  output logic [`RV_REG_AW-1:0] o_rs1addr,
  output logic [`RV_REG_AW-1:0] o_rs2addr,
  output logic [`RV_REG_AW-1:0] o_rdaddr,
  output logic [`RV_XLEN-1:0]   o_rs1data,
  output logic [`RV_XLEN-1:0]   o_rs2data,
  output logic [`RV_XLEN-1:0]   o_imm
);

  import riscv_pkg::*;

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  logic [`RV_XLEN-1:0] imm_i_ext;
  logic [`RV_XLEN-1:0] imm_u_ext;

  // field positions are shared, so the r view serves every format
  assign o_opcode  = i_inst.r_fmt.opcode;
  assign o_func3   = i_inst.r_fmt.funct3;
  assign o_func7_5 = i_inst.r_fmt.funct7[5];  // sub/sra select
  assign o_rs1addr = i_inst.r_fmt.rs1;
  assign o_rs2addr = i_inst.r_fmt.rs2;
  assign o_rdaddr  = i_inst.r_fmt.rd;

  assign imm_i_ext = {{(`RV_XLEN-12){i_inst.i_fmt.imm12[11]}}, i_inst.i_fmt.imm12};

  // lui/auipc immediate, upper 20 bits then sign extended
  assign imm_u_ext = {{(`RV_XLEN-32){i_inst.u_fmt.imm20[19]}}, i_inst.u_fmt.imm20, 12'b0};

  always_comb begin
    case (i_immsrc)
      imm_i:   o_imm = imm_i_ext;
      imm_u:   o_imm = imm_u_ext;
      default: o_imm = imm_i_ext;
    endcase
  end

  // register file, cleared on reset so x0 starts and stays zero
  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_regw) begin
      regs[i_wb_rdaddr] <= i_wb_rddata;
    end
  end

  // write-through, a read in the write cycle sees the new value
  always_comb begin
    if (i_wb_regw && (i_wb_rdaddr == o_rs1addr)) begin
      o_rs1data = i_wb_rddata;
    end else begin
      o_rs1data = regs[o_rs1addr];
    end
  end

  always_comb begin
    if (i_wb_regw && (i_wb_rdaddr == o_rs2addr)) begin
      o_rs2data = i_wb_rddata;
    end else begin
      o_rs2data = regs[o_rs2addr];
    end
  end

endmodule

//--- hw/riscv_fetch.sv
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_fetch (
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  logic                  i_stallpc,   // hold pc
  input  logic                  i_stall_fd,  // hold fetch/decode reg
  input  logic                  i_flush_fd,  // bubble into fetch/decode reg
  input  logic [`RV_INST_W-1:0] i_inst,      // from instruction memory
  output logic [`RV_XLEN-1:0]   o_pc,        // to instruction memory
  output logic [`RV_XLEN-1:0]   o_pc_d,
  output riscv_pkg::inst_u      o_inst_d
);

  localparam logic [`RV_XLEN-1:0] PC_STEP = `RV_XLEN'(4);

  logic [`RV_XLEN-1:0] pc_next;

  // sequential fetch only, no redirection
  assign pc_next = i_stallpc ? o_pc : o_pc + PC_STEP;

  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc <= `RV_PC_RESET;
    end else begin
      o_pc <= pc_next;
    end
  end

  // all-zero word is what control decodes as a no-write bubble
  always_ff @(posedge i_riscv_datapath_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_inst_d <= '0;
    end else if (i_flush_fd) begin  // flush beats stall
      o_inst_d <= '0;
    end else if (!i_stall_fd) begin
      o_inst_d <= i_inst;
    end
  end

  // pc of the instruction in decode, feeds auipc
  always_ff @(posedge i_riscv_datapath_clk) begin
    if (!i_stall_fd) begin
      o_pc_d <= o_pc;
    end
  end

endmodule

//--- hw/riscv_pkg.sv
`include "riscv_config.svh"

package riscv_pkg;

  // r-type view, also used for register addresses of every format
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;  // imm[11:0]
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]           imm20;  // imm[31:12]
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  // one instruction word, three decodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  typedef enum logic {
    imm_i = 1'b0,
    imm_u = 1'b1
  } imm_sel_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  typedef enum logic {
    res_alu = 1'b0,
    res_imm = 1'b1   // lui
  } res_sel_e;

endpackage

//--- hw/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// data path and pc width
`define RV_XLEN 64

// instruction word
`define RV_INST_W 32

// register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// first fetch address out of reset
`define RV_PC_RESET 64'h0000_0000_0000_0000

`endif
